// ==== list.f ====
source/fetch_pkg.sv
source/fetch_control.sv
source/pc_unit.sv
source/predecode.sv
source/muldiv_hold.sv
source/fetch_top.sv
test/instr_mem_model.sv
test/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;

    localparam int pkt_target = 60;
    localparam int cycle_limit = 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  mem_req;
    logic [31:0]           mem_addr;
    logic                  mem_ack;
    logic                  mem_done;
    logic [31:0]           mem_rdata;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    logic                  md_finish;
    fetch_pkg::fetch_pkt_t fetch_pkt;

    int          errors;
    int          pkt_count;
    int          cycle_count;
    logic [31:0] exp_pc;
    logic        wait_redirect;

    fetch_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_ack        (mem_ack),
        .mem_done       (mem_done),
        .mem_rdata      (mem_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .md_finish      (md_finish),
        .fetch_pkt      (fetch_pkt)
    );

    instr_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Expected next pc. Bit 32 set means fetch waits for a redirect.
    function automatic logic [32:0] next_pc(input logic [31:0] pc, input logic [31:0] word);
        logic [31:0] offset;
        offset = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        if (word[6:0] == 7'b1101111) begin
            return {1'b0, pc + offset};
        end else if (word[6:0] == 7'b1100111) begin
            return {1'b1, pc};
        end
        return {1'b0, pc + 32'd4};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] word_addr(input int index);
        return fetch_pkg::reset_pc + 32'(index * 4);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Fetch must stay stopped while execute has not answered.
    task automatic expect_no_request(input int cycles, input string reason);
        repeat (cycles) begin
            next_cycle();
            if (mem_req) begin
                $display("A request was made while waiting for %s", reason);
                errors++;
            end
        end
    endtask

    task automatic load_program();
        logic [31:0] addr;
        for (int i = 0; i < 256; i++) begin
            addr = word_addr(i);
            u_mem.mem[i] = {addr[31:20] ^ addr[19:8] ^ addr[11:0],
                            5'd1, 3'b000, 5'd1, 7'b0010011};
        end
        u_mem.mem[8] = enc_jal(21'd32);
        u_mem.mem[20] = {7'b0000001, 5'd2, 5'd3, 3'b000, 5'd4, 7'b0110011};
        u_mem.mem[24] = {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};
        u_mem.mem[44] = {7'b0000001, 5'd2, 5'd3, 3'b100, 5'd4, 7'b0110011};
        u_mem.mem[48] = enc_jal(21'd48);
    endtask

    // Compare every packet with the reference pc and the memory word.
    initial begin
        logic [32:0] ref_next;
        logic [31:0] exp_word;
        forever begin
            next_cycle();
            if (rst_n && fetch_pkt.valid) begin
                exp_word = u_mem.mem[exp_pc[9:2]];
                if (wait_redirect) begin
                    $display("A packet arrived at pc %h before the JALR redirect", fetch_pkt.pc);
                    errors++;
                end
                if (fetch_pkt.pc != exp_pc) begin
                    $display("Mismatch fetch_pkt.pc: got %h expected %h", fetch_pkt.pc, exp_pc);
                    errors++;
                end
                if (fetch_pkt.instr != exp_word) begin
                    $display("Mismatch fetch_pkt.instr: got %h expected %h",
                             fetch_pkt.instr, exp_word);
                    errors++;
                end
                ref_next = next_pc(exp_pc, exp_word);
                exp_pc = ref_next[31:0];
                wait_redirect = ref_next[32];
                pkt_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d packets seen", cycle_count, pkt_count);
            $display("Errors: %0d", errors + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic ack_seen;
        logic mid_redirect_done;
        rst_n = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        md_finish = 1'b0;
        errors = 0;
        pkt_count = 0;
        cycle_count = 0;
        exp_pc = fetch_pkg::reset_pc;
        wait_redirect = 1'b0;
        mid_redirect_done = 1'b0;
        load_program();
        repeat (3) begin
            next_cycle();
            if (mem_req || fetch_pkt.valid) begin
                $display("The request or the packet valid bit was high during reset");
                errors++;
            end
        end
        rst_n = 1'b1;
        while (!mem_req) begin
            next_cycle();
        end
        if (mem_addr != fetch_pkg::reset_pc) begin
            $display("Mismatch mem_addr: got %h expected %h", mem_addr, fetch_pkg::reset_pc);
            errors++;
        end
        while (pkt_count < pkt_target) begin
            @(posedge clk);
            ack_seen = mem_ack;
            #1;
            if (fetch_pkt.valid && fetch_pkt.instr[6:0] == 7'b1100111) begin
                expect_no_request(6, "the JALR target");
                redirect_valid = 1'b1;
                redirect_pc = word_addr(40);
                exp_pc = word_addr(40);
                wait_redirect = 1'b0;
                next_cycle();
                redirect_valid = 1'b0;
            end else if (fetch_pkt.valid && fetch_pkt.instr[6:0] == 7'b0110011
                         && fetch_pkt.instr[31:25] == 7'b0000001) begin
                expect_no_request(6, "md_finish");
                md_finish = 1'b1;
                next_cycle();
                md_finish = 1'b0;
            end else if (ack_seen && pkt_count >= 34 && !mid_redirect_done) begin
                // The read just accepted is now stale and must produce no packet.
                redirect_valid = 1'b1;
                redirect_pc = word_addr(200);
                exp_pc = word_addr(200);
                mid_redirect_done = 1'b1;
                next_cycle();
                redirect_valid = 1'b0;
            end
        end
        if (!mid_redirect_done) begin
            $display("The redirect during an outstanding read was never issued");
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== test/instr_mem_model.sv ====
`timescale 1ns/10ps

module instr_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_ack,
    output logic        mem_done,
    output logic [31:0] mem_rdata
);

    // 256 words starting at the reset pc; the testbench fills them.
    logic [31:0] mem [0:255];

    integer      seed;
    int          ack_delay;
    int          done_delay;
    logic [31:0] addr_q;

    // Every output changes 1 ns after a rising edge, like the testbench stimulus.
    initial begin
        seed = 5591;
        mem_ack = 1'b0;
        mem_done = 1'b0;
        mem_rdata = '0;
        addr_q = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && mem_req) begin
                ack_delay = $unsigned($random(seed)) % 4;
                done_delay = $unsigned($random(seed)) % 4;
                repeat (ack_delay) begin
                    @(posedge clk);
                    #1;
                end
                addr_q = mem_addr;
                mem_ack = 1'b1;
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
                repeat (done_delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_done = 1'b1;
                mem_rdata = mem[addr_q[9:2]];
                @(posedge clk);
                #1;
                mem_done = 1'b0;
            end
        end
    end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic                       mem_req,
    output logic [fetch_pkg::xlen-1:0] mem_addr,
    input  logic                       mem_ack,
    input  logic                       mem_done,
    input  logic [fetch_pkg::xlen-1:0] mem_rdata,
    input  logic                       redirect_valid,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    input  logic                       md_finish,
    output fetch_pkg::fetch_pkt_t      fetch_pkt
);

    fetch_pkg::instr_word_u     instr;
    fetch_pkg::instr_class_t    cls;
    logic [fetch_pkg::xlen-1:0] pc;
    logic [fetch_pkg::xlen-1:0] jal_target;
    logic                       pc_advance;
    logic                       pc_jump;
    logic                       pc_hold;
    logic                       pkt_valid;
    logic                       md_busy;
    logic                       pkt_valid_q;
    logic [fetch_pkg::xlen-1:0] pkt_pc_q;
    logic [fetch_pkg::xlen-1:0] pkt_instr_q;

    assign instr.raw = mem_rdata;
    assign mem_addr = pc;

    fetch_control u_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_ack        (mem_ack),
        .mem_done       (mem_done),
        .mem_req        (mem_req),
        .cls            (cls),
        .md_busy        (md_busy),
        .redirect_valid (redirect_valid),
        .pc_advance     (pc_advance),
        .pc_jump        (pc_jump),
        .pc_hold        (pc_hold),
        .pkt_valid      (pkt_valid)
    );

    pc_unit u_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_advance     (pc_advance),
        .pc_jump        (pc_jump),
        .pc_hold        (pc_hold),
        .redirect_valid (redirect_valid),
        .jal_target     (jal_target),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    predecode u_predecode (
        .instr      (instr),
        .pc         (pc),
        .cls        (cls),
        .jal_target (jal_target)
    );

    muldiv_hold u_muldiv (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (pkt_valid && cls.is_muldiv),
        .md_finish (md_finish),
        .md_busy   (md_busy)
    );

    // The packet leaves one cycle after mem_done, while the pc moves on the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= pkt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_valid) begin
            pkt_pc_q <= pc;
            pkt_instr_q <= mem_rdata;
        end
    end

    assign fetch_pkt = '{valid: pkt_valid_q, pc: pkt_pc_q, instr: pkt_instr_q};

endmodule

// ==== source/muldiv_hold.sv ====
`timescale 1ns/10ps

module muldiv_hold (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic md_finish,
    output logic md_busy
);

    typedef enum logic [1:0] {
        st_free,
        st_busy,
        st_release
    } md_state_t;

    md_state_t state;
    md_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_free: begin
                // A finish in the start cycle means the unit is already done.
                if (start) begin
                    if (md_finish) begin
                        state_next = st_release;
                    end else begin
                        state_next = st_busy;
                    end
                end
            end
            st_busy: begin
                if (md_finish) begin
                    state_next = st_release;
                end
            end
            st_release: begin
                state_next = st_free;
            end
            default: begin
                state_next = st_free;
            end
        endcase
    end

    // The release cycle keeps fetch stopped until the operation has retired.
    assign md_busy = (state != st_free);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_free;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== source/predecode.sv ====
`timescale 1ns/10ps

module predecode (
    input  fetch_pkg::instr_word_u     instr,
    input  logic [fetch_pkg::xlen-1:0] pc,
    output fetch_pkg::instr_class_t    cls,
    output logic [fetch_pkg::xlen-1:0] jal_target
);

    logic                       op_jal;
    logic                       op_jalr;
    logic                       op_muldiv;
    logic [20:0]                j_imm;
    logic [fetch_pkg::xlen-1:0] j_offset;

    // The opcode sits in the same bits in every format.
    assign op_jal = (instr.i.opcode == fetch_pkg::opc_jal);

    // JALR is only defined with funct3 equal to zero.
    assign op_jalr = (instr.i.opcode == fetch_pkg::opc_jalr) && (instr.i.funct3 == 3'b000);

    // MUL, MULH*, DIV* and REM* share the OP opcode and a distinct funct7.
    assign op_muldiv = (instr.r.opcode == fetch_pkg::opc_op)
                       && (instr.r.funct7 == fetch_pkg::funct7_muldiv);

    always_comb begin
        cls.is_jal = op_jal;
        cls.is_jalr = op_jalr;
        cls.is_muldiv = op_muldiv;
        cls.is_plain = !(op_jal || op_jalr || op_muldiv);
    end

    // The J-type offset imm[20|10:1|11|19:12] sits in bits 31..12 and bit 0 is always zero.
    assign j_imm = {
        instr.raw[31],
        instr.raw[19:12],
        instr.raw[20],
        instr.raw[30:21],
        1'b0
    };

    assign j_offset = {{(fetch_pkg::xlen - 21){j_imm[20]}}, j_imm};

    assign jal_target = pc + j_offset;

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pc_advance,
    input  logic                       pc_jump,
    input  logic                       pc_hold,
    input  logic                       redirect_valid,
    input  logic [fetch_pkg::xlen-1:0] jal_target,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    output logic [fetch_pkg::xlen-1:0] pc
);

    logic [fetch_pkg::xlen-1:0] pc_step;
    logic [fetch_pkg::xlen-1:0] pc_next;

    // The step command is one-hot, so the order of the arms carries no priority.
    always_comb begin
        case (1'b1)
            pc_jump: begin
                pc_step = jal_target;
            end
            pc_advance: begin
                pc_step = pc + fetch_pkg::pc_inc;
            end
            pc_hold: begin
                pc_step = pc;
            end
            default: begin
                pc_step = pc;
            end
        endcase
    end

    // A redirect from execute overrides whatever fetch decided this cycle.
    assign pc_next = redirect_valid ? redirect_pc : pc_step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= fetch_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// ==== source/fetch_control.sv ====
`timescale 1ns/10ps

module fetch_control (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mem_ack,
    input  logic                    mem_done,
    output logic                    mem_req,
    input  fetch_pkg::instr_class_t cls,
    input  logic                    md_busy,
    input  logic                    redirect_valid,
    output logic                    pc_advance,
    output logic                    pc_jump,
    output logic                    pc_hold,
    output logic                    pkt_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_data,
        st_recover,
        st_wait_jalr
    } state_t;

    state_t state;
    state_t state_next;
    logic   stale;
    logic   stale_next;
    logic   accept;
    logic   req_next;

    // The memory only acknowledges while a request is up, which happens in idle alone.
    assign accept = mem_req && mem_ack;

    // A read that crossed a redirect belongs to the old path and is dropped.
    assign pkt_valid = (state == st_wait_data) && mem_done && !stale && !redirect_valid;

    always_comb begin
        state_next = state;
        stale_next = stale;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_next = st_wait_data;
                    stale_next = redirect_valid;
                end
            end
            st_wait_data: begin
                if (mem_done) begin
                    stale_next = 1'b0;
                    if (pkt_valid && cls.is_jalr) begin
                        state_next = st_wait_jalr;
                    end else begin
                        state_next = st_recover;
                    end
                end else if (redirect_valid) begin
                    stale_next = 1'b1;
                end
            end
            st_recover: begin
                state_next = st_idle;
            end
            st_wait_jalr: begin
                // Execute delivers the JALR target as a redirect.
                if (redirect_valid) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // The request is held from idle until the address is accepted.
    assign req_next = (state_next == st_idle) && !md_busy;

    // Step command for the pc. A JALR leaves the pc in place until the redirect.
    always_comb begin
        pc_jump = pkt_valid && cls.is_jal;
        pc_advance = pkt_valid && (cls.is_plain || cls.is_muldiv);
        pc_hold = !(pc_jump || pc_advance);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            stale <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            state <= state_next;
            stale <= stale_next;
            mem_req <= req_next;
        end
    end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // Data and address width of the core.
    localparam int xlen = 32;

    // First fetch address after reset.
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // Distance between two sequential instructions.
    localparam logic [xlen-1:0] pc_inc = 32'd4;

    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_op = 7'b0110011;

    // A register-register operation with this funct7 belongs to the M extension.
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // The same fetched word seen as R-type, as I-type or as plain bits.
    // The J-type immediate is scattered, so it is rebuilt from the raw view.
    typedef union packed {
        instr_r_t        r;
        instr_i_t        i;
        logic [xlen-1:0] raw;
    } instr_word_u;

    // Exactly one flag is set for every returned word.
    typedef struct packed {
        logic is_jal;
        logic is_jalr;
        logic is_muldiv;
        logic is_plain;
    } instr_class_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_pkt_t;

endpackage
